/* include/cdc_fifo_defs.svh */
`ifndef CDC_FIFO_DEFS_SVH
`define CDC_FIFO_DEFS_SVH

// Data path and storage size
`define FIFO_DATA_WIDTH 8
`define FIFO_DEPTH 16
`define FIFO_ADDR_WIDTH 4

// Flag levels in words
`define FIFO_AFULL_LEVEL 14
`define FIFO_AEMPTY_LEVEL 1

`endif

/* logic/cdc_fifo_pkg.sv */
`include "cdc_fifo_defs.svh"

package cdc_fifo_pkg;

  typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;
  typedef logic [`FIFO_ADDR_WIDTH-1:0] addr_t;

  // Top bit of a pointer is the wrap bit
  typedef logic [`FIFO_ADDR_WIDTH:0] ptr_t;
  typedef logic [`FIFO_ADDR_WIDTH:0] count_t;

  // Each binary bit is the XOR of all Gray bits at or above it
  function automatic ptr_t gray_to_bin(input ptr_t gray);
    ptr_t bin;
    for (int i = 0; i < $bits(ptr_t); i++) begin
      bin[i] = ^(gray >> i);
    end
    return bin;
  endfunction

endpackage

/* logic/fifo_dpram.sv */
`timescale 1ns/100ps

`include "cdc_fifo_defs.svh"

module fifo_dpram (
  input  logic                wr_clk,
  input  logic                wr_accept,
  input  cdc_fifo_pkg::addr_t wr_addr,
  input  cdc_fifo_pkg::data_t wr_data,
  input  logic                rd_clk,
  input  logic                rd_rst_n,
  input  logic                rd_accept,
  input  cdc_fifo_pkg::addr_t rd_addr,
  output cdc_fifo_pkg::data_t rd_data
);

  import cdc_fifo_pkg::*;

  data_t mem [`FIFO_DEPTH];

  // Write port, write clock domain
  always_ff @(posedge wr_clk) begin
    if (wr_accept) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port, loads only on an accepted read
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_accept) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* logic/gray_ptr_sync.sv */
`timescale 1ns/100ps

module gray_ptr_sync (
  input  logic               clk,
  input  logic               rst_n,
  input  cdc_fifo_pkg::ptr_t gray_in,
  output cdc_fifo_pkg::ptr_t gray_sync
);

  import cdc_fifo_pkg::*;

  // First stage may go metastable
  ptr_t gray_meta;

  // Only one bit moves per source cycle, so either sampled value is a valid pointer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gray_meta <= '0;
      gray_sync <= '0;
    end else begin
      gray_meta <= gray_in;
      gray_sync <= gray_meta;
    end
  end

endmodule

/* logic/fifo_wr_ctrl.sv */
`timescale 1ns/100ps

`include "cdc_fifo_defs.svh"

module fifo_wr_ctrl (
  input  logic                wr_clk,
  input  logic                wr_rst_n,
  input  logic                wr_en,
  input  cdc_fifo_pkg::ptr_t  rd_gray_sync,
  output logic                wr_accept,
  output cdc_fifo_pkg::addr_t wr_addr,
  output cdc_fifo_pkg::ptr_t  wr_gray,
  output logic                full,
  output logic                afull
);

  import cdc_fifo_pkg::*;

  ptr_t   wr_ptr;
  ptr_t   wr_ptr_nxt;
  ptr_t   wr_gray_nxt;
  ptr_t   rd_ptr_sync;
  count_t wr_count_nxt;
  logic   full_nxt;
  logic   afull_nxt;

  // **************************************************
  // Write pointer
  // **************************************************
  assign wr_accept   = wr_en & ~full;
  assign wr_ptr_nxt  = wr_ptr + ptr_t'(wr_accept);
  assign wr_gray_nxt = (wr_ptr_nxt >> 1) ^ wr_ptr_nxt;
  assign wr_addr     = wr_ptr[`FIFO_ADDR_WIDTH-1:0];

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr  <= '0;
      wr_gray <= '0;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      wr_gray <= wr_gray_nxt;
    end
  end

  // **************************************************
  // Full flags
  // **************************************************
  // Full when writer is one lap ahead: top two Gray bits differ, rest equal
  assign full_nxt = (wr_gray_nxt == {~rd_gray_sync[`FIFO_ADDR_WIDTH:`FIFO_ADDR_WIDTH-1],
                                     rd_gray_sync[`FIFO_ADDR_WIDTH-2:0]});

  assign rd_ptr_sync  = gray_to_bin(rd_gray_sync);
  assign wr_count_nxt = count_t'(wr_ptr_nxt - rd_ptr_sync);
  assign afull_nxt    = (wr_count_nxt >= count_t'(`FIFO_AFULL_LEVEL));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= afull_nxt;
    end
  end

endmodule

/* logic/fifo_rd_ctrl.sv */
`timescale 1ns/100ps

`include "cdc_fifo_defs.svh"

module fifo_rd_ctrl (
  input  logic                rd_clk,
  input  logic                rd_rst_n,
  input  logic                rd_en,
  input  cdc_fifo_pkg::ptr_t  wr_gray_sync,
  output logic                rd_accept,
  output cdc_fifo_pkg::addr_t rd_addr,
  output cdc_fifo_pkg::ptr_t  rd_gray,
  output logic                empty,
  output logic                aempty,
  output logic                rd_data_valid
);

  import cdc_fifo_pkg::*;

  ptr_t   rd_ptr;
  ptr_t   rd_ptr_nxt;
  ptr_t   rd_gray_nxt;
  ptr_t   wr_ptr_sync;
  count_t rd_count_nxt;
  logic   empty_nxt;
  logic   aempty_nxt;

  // **************************************************
  // Read pointer
  // **************************************************
  assign rd_accept   = rd_en & ~empty;
  assign rd_ptr_nxt  = rd_ptr + ptr_t'(rd_accept);
  assign rd_gray_nxt = (rd_ptr_nxt >> 1) ^ rd_ptr_nxt;
  assign rd_addr     = rd_ptr[`FIFO_ADDR_WIDTH-1:0];

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr  <= '0;
      rd_gray <= '0;
    end else begin
      rd_ptr  <= rd_ptr_nxt;
      rd_gray <= rd_gray_nxt;
    end
  end

  // **************************************************
  // Empty flags and read valid
  // **************************************************
  assign empty_nxt = (rd_gray_nxt == wr_gray_sync);

  assign wr_ptr_sync  = gray_to_bin(wr_gray_sync);
  assign rd_count_nxt = count_t'(wr_ptr_sync - rd_ptr_nxt);
  assign aempty_nxt   = (rd_count_nxt <= count_t'(`FIFO_AEMPTY_LEVEL));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty         <= 1'b1;
      aempty        <= 1'b1;
      rd_data_valid <= 1'b0;
    end else begin
      empty         <= empty_nxt;
      aempty        <= aempty_nxt;
      // Lines up with the RAM output register
      rd_data_valid <= rd_accept;
    end
  end

endmodule

/* logic/cdc_fifo.sv */
`timescale 1ns/100ps

module cdc_fifo (
  input  logic                wr_clk,
  input  logic                wr_rst_n,
  input  logic                wr_en,
  input  cdc_fifo_pkg::data_t wr_data,
  input  logic                rd_clk,
  input  logic                rd_rst_n,
  input  logic                rd_en,
  output cdc_fifo_pkg::data_t rd_data,
  output logic                rd_data_valid,
  output logic                full,
  output logic                afull,
  output logic                empty,
  output logic                aempty
);

  import cdc_fifo_pkg::*;

  logic  wr_accept;
  logic  rd_accept;
  addr_t wr_addr;
  addr_t rd_addr;
  ptr_t  wr_gray;
  ptr_t  rd_gray;
  ptr_t  wr_gray_sync;
  ptr_t  rd_gray_sync;

  // **************************************************
  // Write domain
  // **************************************************
  fifo_wr_ctrl u_wr_ctrl (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .wr_en        (wr_en),
    .rd_gray_sync (rd_gray_sync),
    .wr_accept    (wr_accept),
    .wr_addr      (wr_addr),
    .wr_gray      (wr_gray),
    .full         (full),
    .afull        (afull)
  );

  // Read pointer into the write domain
  gray_ptr_sync u_rd2wr (
    .clk       (wr_clk),
    .rst_n     (wr_rst_n),
    .gray_in   (rd_gray),
    .gray_sync (rd_gray_sync)
  );

  // **************************************************
  // Read domain
  // **************************************************
  fifo_rd_ctrl u_rd_ctrl (
    .rd_clk        (rd_clk),
    .rd_rst_n      (rd_rst_n),
    .rd_en         (rd_en),
    .wr_gray_sync  (wr_gray_sync),
    .rd_accept     (rd_accept),
    .rd_addr       (rd_addr),
    .rd_gray       (rd_gray),
    .empty         (empty),
    .aempty        (aempty),
    .rd_data_valid (rd_data_valid)
  );

  // Write pointer into the read domain
  gray_ptr_sync u_wr2rd (
    .clk       (rd_clk),
    .rst_n     (rd_rst_n),
    .gray_in   (wr_gray),
    .gray_sync (wr_gray_sync)
  );

  // Storage
  fifo_dpram u_ram (
    .wr_clk    (wr_clk),
    .wr_accept (wr_accept),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_accept (rd_accept),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

endmodule

/* verif/cdc_fifo_assert.sv */
`timescale 1ns/100ps

`include "cdc_fifo_defs.svh"

module cdc_fifo_assert (
  input logic                 clk,
  input logic                 rst_n,
  input cdc_fifo_pkg::ptr_t   ptr,
  input logic                 stop,
  input logic                 valid,
  input cdc_fifo_pkg::count_t count
);

  import cdc_fifo_pkg::*;

  // Pointer never moves while its side is blocked
  a_no_accept_when_stopped: assert property (
    @(posedge clk) disable iff (!rst_n) stop |=> ptr == $past(ptr)
  ) else $error("Pointer moved while blocked");

  // Read data valid only in the cycle after the read pointer moved
  a_valid_after_accept: assert property (
    @(posedge clk) disable iff (!rst_n) valid |-> ptr == ptr_t'($past(ptr) + 1'b1)
  ) else $error("Data valid without an accepted read one cycle before");

  a_count_in_range: assert property (
    @(posedge clk) disable iff (!rst_n) count <= count_t'(`FIFO_DEPTH)
  ) else $error("Fill count above FIFO depth");

endmodule

bind fifo_wr_ctrl cdc_fifo_assert u_wr_assert (
  .clk    (wr_clk),
  .rst_n  (wr_rst_n),
  .ptr    (wr_ptr),
  .stop   (full),
  .valid  (1'b0),
  .count  (wr_count_nxt)
);

bind fifo_rd_ctrl cdc_fifo_assert u_rd_assert (
  .clk    (rd_clk),
  .rst_n  (rd_rst_n),
  .ptr    (rd_ptr),
  .stop   (empty),
  .valid  (rd_data_valid),
  .count  (rd_count_nxt)
);

/* verif/cdc_fifo_tb.sv */
`timescale 1ns/100ps

`include "cdc_fifo_defs.svh"

module cdc_fifo_tb;

  import cdc_fifo_pkg::*;

  localparam int PHASE_TIMEOUT = 5000;
  localparam int NUM_ROWS = 9;

  typedef struct packed {
    int n_wr;
    int n_rd;
    int wr_pct;
    int rd_pct;
    bit blind;
    int exp_k;
  } row_t;

  logic  wr_clk;
  logic  wr_rst_n;
  logic  wr_en;
  data_t wr_data;
  logic  rd_clk;
  logic  rd_rst_n;
  logic  rd_en;
  data_t rd_data;
  logic  rd_data_valid;
  logic  full;
  logic  afull;
  logic  empty;
  logic  aempty;

  row_t  rows [NUM_ROWS];
  data_t model_q [$];
  int    flag_errs = 0;
  int    data_errs = 0;
  int    stray_reads = 0;
  int    other_errs = 0;
  int    empty_pulses = 0;
  int    seed;

  cdc_fifo UUT (.*);

  initial begin
    wr_clk = 1'b0;
    forever #3.5 wr_clk = ~wr_clk;
  end

  // Offset keeps the two clocks from ever sharing an edge time
  initial begin
    rd_clk = 1'b0;
    #1.2;
    forever #5 rd_clk = ~rd_clk;
  end

  // **************************************************
  // Scoreboard
  // **************************************************
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      model_q.push_back(wr_data);
    end
  end

  // Read word is stable in the middle of the rd_clk cycle
  always @(negedge rd_clk) begin
    data_t exp_data;
    if (rd_rst_n && rd_data_valid) begin
      if (model_q.size() == 0) begin
        stray_reads++;
        $display("Read data valid at %0t with no word left to read", $time);
      end else begin
        exp_data = model_q.pop_front();
        if (rd_data !== exp_data) begin
          data_errs++;
          $display("ERR rd_data: expected 0x%02h, got 0x%02h", exp_data, rd_data);
        end
      end
    end
  end

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errs++;
      $display("ERR %s: expected 0x%0h, got 0x%0h", name, exp, act);
    end
  endtask

  // full seen at the falling edge is the value that gates the next rising edge
  task automatic write_phase(input int n, input int pct, input bit blind);
    int offered;
    int cycles;
    offered = 0;
    cycles = 0;
    while (offered < n && cycles < PHASE_TIMEOUT) begin
      @(negedge wr_clk);
      cycles++;
      if ((blind || !full) && $urandom_range(99) < pct) begin
        wr_en = 1'b1;
        wr_data = data_t'($urandom());
        offered++;
      end else begin
        wr_en = 1'b0;
      end
    end
    @(negedge wr_clk);
    wr_en = 1'b0;
    if (offered < n) begin
      other_errs++;
      $display("Write phase timed out after %0d of %0d words", offered, n);
    end
  endtask

  // Counts accepted reads; a blind reader also pulses rd_en while empty
  task automatic read_phase(input int n, input int pct, input bit blind);
    int taken;
    int cycles;
    taken = 0;
    cycles = 0;
    while (taken < n && cycles < PHASE_TIMEOUT) begin
      @(negedge rd_clk);
      cycles++;
      if ((blind || !empty) && $urandom_range(99) < pct) begin
        rd_en = 1'b1;
        if (empty) begin
          empty_pulses++;
        end else begin
          taken++;
        end
      end else begin
        rd_en = 1'b0;
      end
    end
    @(negedge rd_clk);
    rd_en = 1'b0;
    if (taken < n) begin
      other_errs++;
      $display("Read phase timed out after %0d of %0d words", taken, n);
    end
  endtask

  task automatic settle_and_check(input int exp_k);
    repeat (10) @(negedge rd_clk);
    if (model_q.size() != exp_k) begin
      flag_errs++;
      $display("ERR fill_level: expected 0x%0h, got 0x%0h", exp_k, model_q.size());
    end
    compare_flag("full", exp_k == `FIFO_DEPTH, full);
    compare_flag("afull", exp_k >= `FIFO_AFULL_LEVEL, afull);
    compare_flag("empty", exp_k == 0, empty);
    compare_flag("aempty", exp_k <= `FIFO_AEMPTY_LEVEL, aempty);
  endtask

  // **************************************************
  // Main sequence
  // **************************************************
  initial begin
    seed = 32'h5595;
    void'($urandom(seed));
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en = 1'b0;
    rd_en = 1'b0;
    wr_data = '0;

    // Words to write, words to read, wr_en %, rd_en %, ignore flags, fill after row
    rows[0] = '{0, 0, 0, 0, 1'b0, 0};
    rows[1] = '{1, 0, 100, 0, 1'b0, 1};
    rows[2] = '{1, 0, 100, 0, 1'b0, 2};
    rows[3] = '{11, 0, 100, 0, 1'b0, 13};
    rows[4] = '{1, 0, 100, 0, 1'b0, 14};
    // Rows 1 to 5 offer 20 writes and the last 4 meet a full FIFO
    rows[5] = '{6, 0, 100, 0, 1'b1, 16};
    rows[6] = '{0, 16, 0, 100, 1'b0, 0};
    rows[7] = '{300, 300, 60, 50, 1'b0, 0};
    rows[8] = '{8, 8, 15, 100, 1'b1, 0};

    repeat (16) @(posedge rd_clk);
    @(negedge wr_clk);
    // Flag values held by reset
    compare_flag("full", 1'b0, full);
    compare_flag("afull", 1'b0, afull);
    compare_flag("empty", 1'b1, empty);
    compare_flag("aempty", 1'b1, aempty);
    wr_rst_n = 1'b1;
    @(negedge rd_clk);
    rd_rst_n = 1'b1;
    @(negedge rd_clk);
    compare_flag("rd_data_valid", 1'b0, rd_data_valid);
    if (rd_data !== '0) begin
      data_errs++;
      $display("ERR rd_data: expected 0x00, got 0x%02h", rd_data);
    end

    for (int r = 0; r < NUM_ROWS; r++) begin
      fork
        write_phase(rows[r].n_wr, rows[r].wr_pct, rows[r].blind);
        read_phase(rows[r].n_rd, rows[r].rd_pct, rows[r].blind);
      join
      settle_and_check(rows[r].exp_k);
    end
    if (empty_pulses == 0) begin
      other_errs++;
      $display("rd_en was never raised while the FIFO was empty");
    end

    $display("Errors: %0d flag, %0d data, %0d stray reads, %0d other",
             flag_errs, data_errs, stray_reads, other_errs);
    if (flag_errs + data_errs + stray_reads + other_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+include
logic/cdc_fifo_pkg.sv
logic/fifo_dpram.sv
logic/gray_ptr_sync.sv
logic/fifo_wr_ctrl.sv
logic/fifo_rd_ctrl.sv
logic/cdc_fifo.sv
verif/cdc_fifo_assert.sv
verif/cdc_fifo_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the CDC FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module cdc_fifo_tb -f flist.f -Mdir "$BUILD_DIR" -o cdc_fifo_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/cdc_fifo_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Test OK" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
